//--- design/udp_tx_cfg.svh
`ifndef UDP_TX_CFG_SVH
`define UDP_TX_CFG_SVH

// FIFO depths, as log2
`define DATA_FIFO_AW      10
`define CTRL_FIFO_AW      4

// Fill levels that raise almost-full
`define DATA_AFULL_LEVEL  1000
`define CTRL_AFULL_LEVEL  14

// Fixed protocol fields
`define TX_TTL            8'h40
`define IP_PROTO_UDP      8'h11
`define ETHERTYPE_IPV4    16'h0800
`define MCAST_MAC_PREFIX  24'h01005e

// Header sizes in bytes
`define IP_OVERHEAD_BYTES 16'd28   // IP plus UDP header
`define UDP_HDR_BYTES     16'd8

`endif

//--- design/udp_tx_pkg.sv
`default_nettype none

package udp_tx_pkg;

  typedef logic [63:0] tx_word_t;     // Payload word and MAC beat
  typedef logic [7:0]  byte_mask_t;   // Byte-valid mask per beat
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [15:0] word_count_t;  // Word counts and byte lengths
  typedef logic [7:0]  arp_index_t;

  // Framer states in beat order
  typedef enum logic [3:0] {
    idle,
    hdr_1,
    hdr_1_mcast,
    hdr_2,
    hdr_3,
    hdr_4,
    hdr_5,
    hdr_6,
    send_data,
    send_last
  } tx_state_e;

endpackage

`default_nettype wire

//--- design/sync_fifo.sv
`default_nettype none

module sync_fifo #(
  parameter int WIDTH       = 64,
  parameter int AW          = 4,
  parameter int AFULL_LEVEL = 14,
  parameter bit SHOW_AHEAD  = 1'b0
) (
  input  wire              mac_clk,
  input  wire              app_rst,
  input  wire              wr_en,
  input  wire [WIDTH-1:0]  wr_data,
  input  wire              rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             empty,
  output logic             afull,
  output logic             overflow
);

  localparam int DEPTH = 1 << AW;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [AW:0]      count;   // One bit wider to tell full from empty
  logic             full;
  logic             do_wr;
  logic             do_rd;

  assign full     = count == (AW+1)'(DEPTH);
  assign empty    = count == '0;
  assign afull    = count >= (AW+1)'(AFULL_LEVEL);
  assign overflow = wr_en && full;   // Write is dropped
  assign do_wr    = wr_en && !full;
  assign do_rd    = rd_en && !empty;

  always_ff @(posedge mac_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + AW'(do_wr);
      rd_ptr <= rd_ptr + AW'(do_rd);
      count  <= count + (AW+1)'(do_wr) - (AW+1)'(do_rd);
    end
  end

  if (SHOW_AHEAD) begin : g_show_ahead
    assign rd_data = mem[rd_ptr];   // Head visible while not empty
  end else begin : g_reg_read
    // Word appears the cycle after rd_en and then holds
    always_ff @(posedge mac_clk) begin
      if (do_rd) begin
        rd_data <= mem[rd_ptr];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/tx_ingress.sv
`default_nettype none
`include "udp_tx_cfg.svh"

module tx_ingress (
  input  wire                     mac_clk,
  input  wire                     app_rst,
  input  wire                     app_tx_valid,
  input  wire                     app_tx_end_of_frame,
  input  wire udp_tx_pkg::tx_word_t  app_tx_data,
  input  wire udp_tx_pkg::ip_addr_t  app_tx_dest_ip,
  input  wire udp_tx_pkg::udp_port_t app_tx_dest_port,
  output logic                    app_tx_afull,
  output logic                    app_tx_overflow,
  input  wire                     data_rd,
  output udp_tx_pkg::tx_word_t    data_rd_data,
  input  wire                     ctrl_rd,
  output udp_tx_pkg::ip_addr_t    ctrl_ip,
  output udp_tx_pkg::udp_port_t   ctrl_port,
  output udp_tx_pkg::word_count_t ctrl_words,
  output logic                    ctrl_empty
);
  import udp_tx_pkg::*;

  logic        in_valid;
  logic        ctrl_wr;    // Registered end of frame
  tx_word_t    in_data;
  ip_addr_t    in_ip;
  udp_port_t   in_port;
  word_count_t word_cnt;
  logic [63:0] ctrl_head;
  logic        data_afull;
  logic        ctrl_afull;
  logic        data_ovf;
  logic        ctrl_ovf;

  always_ff @(posedge mac_clk) begin
    in_data <= app_tx_data;
    in_ip   <= app_tx_dest_ip;
    in_port <= app_tx_dest_port;
  end

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      in_valid <= 1'b0;
      ctrl_wr  <= 1'b0;
      word_cnt <= 16'd1;
    end else begin
      in_valid <= app_tx_valid;
      ctrl_wr  <= app_tx_valid && app_tx_end_of_frame;
      // Last word is counted ahead, so the count is complete when ctrl_wr fires
      if (ctrl_wr) begin
        word_cnt <= 16'd1;
      end else if (in_valid) begin
        word_cnt <= word_cnt + 16'd1;
      end
    end
  end

  // Sticky until reset
  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      app_tx_overflow <= 1'b0;
    end else if (data_ovf || ctrl_ovf) begin
      app_tx_overflow <= 1'b1;
    end
  end

  assign app_tx_afull = data_afull || ctrl_afull;

  sync_fifo #(
    .WIDTH       (64),
    .AW          (`DATA_FIFO_AW),
    .AFULL_LEVEL (`DATA_AFULL_LEVEL),
    .SHOW_AHEAD  (1'b0)
  ) data_fifo_i (
    .mac_clk  (mac_clk),
    .app_rst  (app_rst),
    .wr_en    (in_valid),
    .wr_data  (in_data),
    .rd_en    (data_rd),
    .rd_data  (data_rd_data),
    .empty    (),
    .afull    (data_afull),
    .overflow (data_ovf)
  );

  sync_fifo #(
    .WIDTH       (64),
    .AW          (`CTRL_FIFO_AW),
    .AFULL_LEVEL (`CTRL_AFULL_LEVEL),
    .SHOW_AHEAD  (1'b1)
  ) ctrl_fifo_i (
    .mac_clk  (mac_clk),
    .app_rst  (app_rst),
    .wr_en    (ctrl_wr),
    .wr_data  ({word_cnt, in_port, in_ip}),
    .rd_en    (ctrl_rd),
    .rd_data  (ctrl_head),
    .empty    (ctrl_empty),
    .afull    (ctrl_afull),
    .overflow (ctrl_ovf)
  );

  assign ctrl_words = ctrl_head[63:48];
  assign ctrl_port  = ctrl_head[47:32];
  assign ctrl_ip    = ctrl_head[31:0];

endmodule

`default_nettype wire

//--- design/arp_cache_apb.sv
`default_nettype none

module arp_cache_apb (
  input  wire                        mac_clk,
  input  wire                        app_rst,
  input  wire                        psel,
  input  wire                        penable,
  input  wire                        pwrite,
  input  wire [10:0]                 paddr,
  input  wire [31:0]                 pwdata,
  output logic [31:0]                prdata,
  input  wire udp_tx_pkg::ip_addr_t  ctrl_ip,
  input  wire udp_tx_pkg::ip_addr_t  local_ip,
  input  wire udp_tx_pkg::ip_addr_t  local_netmask,
  input  wire udp_tx_pkg::arp_index_t local_gateway,
  output udp_tx_pkg::mac_addr_t      next_hop_mac
);
  import udp_tx_pkg::*;

  // Table split by APB half, bits 31:0 and 47:32
  logic [31:0] mac_lo [256];
  logic [15:0] mac_hi [256];

  arp_index_t apb_idx;
  arp_index_t hop_idx;
  logic       apb_wr;
  logic       apb_setup_rd;
  logic       on_subnet;

  assign apb_idx      = paddr[10:3];
  assign apb_wr       = psel && penable && pwrite;
  assign apb_setup_rd = psel && !penable && !pwrite;

  // Off-subnet traffic goes to the gateway entry
  assign on_subnet = (ctrl_ip & local_netmask) == (local_ip & local_netmask);
  assign hop_idx   = on_subnet ? ctrl_ip[7:0] : local_gateway;

  always_ff @(posedge mac_clk) begin
    if (apb_wr && !paddr[2]) begin
      mac_lo[apb_idx] <= pwdata;
    end
    if (apb_wr && paddr[2]) begin
      mac_hi[apb_idx] <= pwdata[15:0];
    end
  end

  // Read captured in setup so it is ready in the access phase
  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      prdata <= '0;
    end else if (apb_setup_rd) begin
      prdata <= paddr[2] ? {16'h0000, mac_hi[apb_idx]} : mac_lo[apb_idx];
    end
  end

  always_ff @(posedge mac_clk) begin
    next_hop_mac <= {mac_hi[hop_idx], mac_lo[hop_idx]};
  end

endmodule

`default_nettype wire

//--- design/ip_header_calc.sv
`default_nettype none
`include "udp_tx_cfg.svh"

module ip_header_calc (
  input  wire                         mac_clk,
  input  wire                         app_rst,
  input  wire udp_tx_pkg::ip_addr_t   ctrl_ip,
  input  wire udp_tx_pkg::word_count_t ctrl_words,
  input  wire udp_tx_pkg::ip_addr_t   local_ip,
  output udp_tx_pkg::word_count_t     ip_length,
  output udp_tx_pkg::word_count_t     udp_length,
  output logic [15:0]                 ip_checksum
);

  logic [19:0] sum_0;   // Nine 16-bit terms
  logic [16:0] sum_1;

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      ip_length   <= '0;
      udp_length  <= '0;
      sum_0       <= '0;
      sum_1       <= '0;
      ip_checksum <= '0;
    end else begin
      ip_length  <= {ctrl_words[12:0], 3'b000} + `IP_OVERHEAD_BYTES;
      udp_length <= {ctrl_words[12:0], 3'b000} + `UDP_HDR_BYTES;

      sum_0 <= 20'(16'h4500) +               // Version, IHL, DSCP
               20'(ip_length) +
               20'(16'h0000) +               // ID
               20'(16'h4000) +               // Don't fragment
               20'({`TX_TTL, `IP_PROTO_UDP}) +
               20'(local_ip[31:16]) +
               20'(local_ip[15:0]) +
               20'(ctrl_ip[31:16]) +
               20'(ctrl_ip[15:0]);
      // Fold carries back in
      sum_1       <= 17'(sum_0[15:0]) + 17'(sum_0[19:16]);
      ip_checksum <= ~(sum_1[15:0] + 16'(sum_1[16]));
    end
  end

endmodule

`default_nettype wire

//--- design/udp_frame_tx.sv
`default_nettype none
`include "udp_tx_cfg.svh"

module udp_frame_tx (
  input  wire                          mac_clk,
  input  wire                          app_rst,
  input  wire                          ctrl_empty,
  input  wire udp_tx_pkg::ip_addr_t    ctrl_ip,
  input  wire udp_tx_pkg::udp_port_t   ctrl_port,
  input  wire udp_tx_pkg::word_count_t ctrl_words,
  input  wire udp_tx_pkg::tx_word_t    data_rd_data,
  input  wire udp_tx_pkg::mac_addr_t   next_hop_mac,
  input  wire udp_tx_pkg::word_count_t ip_length,
  input  wire udp_tx_pkg::word_count_t udp_length,
  input  wire [15:0]                   ip_checksum,
  input  wire                          local_enable,
  input  wire                          app_tx_overflow,
  input  wire udp_tx_pkg::mac_addr_t   local_mac,
  input  wire udp_tx_pkg::ip_addr_t    local_ip,
  input  wire udp_tx_pkg::udp_port_t   local_port,
  input  wire                          mac_tx_ack,
  output logic                         data_rd,
  output logic                         ctrl_rd,
  output logic                         mac_tx_start,
  output udp_tx_pkg::tx_word_t         mac_tx_data,
  output udp_tx_pkg::byte_mask_t       mac_tx_data_valid
);
  import udp_tx_pkg::*;

  tx_state_e   state;
  word_count_t words_left;   // Words still to fetch after the current one
  logic [15:0] leftover;     // Last two bytes of the previous word
  logic        start_ok;
  mac_addr_t   dest_mac;
  tx_word_t    beat;         // First wire byte in bits 63:56

  assign start_ok     = !ctrl_empty && local_enable && !app_tx_overflow;
  assign mac_tx_start = (state == idle) && start_ok;
  assign ctrl_rd      = state == send_last;

  // Fetch one cycle ahead of the beat that uses the word
  assign data_rd = (state == hdr_5) ||
                   ((state == hdr_6 || state == send_data) && words_left != '0);

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (start_ok) begin
            state <= (ctrl_ip[31:28] == 4'b1110) ? hdr_1_mcast : hdr_1;
          end
        end
        hdr_1, hdr_1_mcast: begin
          if (mac_tx_ack) begin
            state <= hdr_2;
          end
        end
        hdr_2: state <= hdr_3;
        hdr_3: state <= hdr_4;
        hdr_4: state <= hdr_5;
        hdr_5: state <= hdr_6;
        hdr_6, send_data: begin
          state <= (words_left == '0) ? send_last : send_data;
        end
        send_last: state <= idle;
        default:   state <= idle;
      endcase
    end
  end

  always_ff @(posedge mac_clk) begin
    leftover <= data_rd_data[15:0];
    if (state == idle) begin
      words_left <= ctrl_words - 16'd1;
    end else if (data_rd && state != hdr_5) begin
      words_left <= words_left - 16'd1;
    end
  end

  // Multicast maps the low 23 bits of the group address
  assign dest_mac = (state == hdr_1_mcast) ? {`MCAST_MAC_PREFIX, 1'b0, ctrl_ip[22:0]}
                                           : next_hop_mac;

  always_comb begin
    case (state)
      hdr_1, hdr_1_mcast: beat = {dest_mac, local_mac[47:32]};
      hdr_2:     beat = {local_mac[31:0], `ETHERTYPE_IPV4, 16'h4500};
      hdr_3:     beat = {ip_length, 16'h0000, 16'h4000, `TX_TTL, `IP_PROTO_UDP};
      hdr_4:     beat = {ip_checksum, local_ip, ctrl_ip[31:16]};
      hdr_5:     beat = {ctrl_ip[15:0], local_port, ctrl_port, udp_length};
      hdr_6:     beat = {16'h0000, data_rd_data[63:16]};   // No UDP checksum
      send_data: beat = {leftover, data_rd_data[63:16]};
      send_last: beat = {leftover, 48'h0};
      default:   beat = '0;
    endcase
  end

  // MAC takes bits 7:0 first
  assign mac_tx_data = {<<8{beat}};

  always_comb begin
    case (state)
      idle:      mac_tx_data_valid = 8'h00;
      send_last: mac_tx_data_valid = 8'h03;   // Two trailing bytes
      default:   mac_tx_data_valid = 8'hff;
    endcase
  end

endmodule

`default_nettype wire

//--- design/udp_tx_top.sv
`default_nettype none

module udp_tx_top (
  input  wire                          mac_clk,
  input  wire                          app_rst,
  // Application
  input  wire                          app_tx_valid,
  input  wire                          app_tx_end_of_frame,
  input  wire udp_tx_pkg::tx_word_t    app_tx_data,
  input  wire udp_tx_pkg::ip_addr_t    app_tx_dest_ip,
  input  wire udp_tx_pkg::udp_port_t   app_tx_dest_port,
  output logic                         app_tx_afull,
  output logic                         app_tx_overflow,
  // Local settings
  input  wire                          local_enable,
  input  wire udp_tx_pkg::mac_addr_t   local_mac,
  input  wire udp_tx_pkg::ip_addr_t    local_ip,
  input  wire udp_tx_pkg::udp_port_t   local_port,
  input  wire udp_tx_pkg::arp_index_t  local_gateway,
  input  wire udp_tx_pkg::ip_addr_t    local_netmask,
  // APB host port to the ARP cache
  input  wire                          psel,
  input  wire                          penable,
  input  wire                          pwrite,
  input  wire [10:0]                   paddr,
  input  wire [31:0]                   pwdata,
  output logic [31:0]                  prdata,
  // MAC
  input  wire                          mac_tx_ack,
  output udp_tx_pkg::tx_word_t         mac_tx_data,
  output udp_tx_pkg::byte_mask_t       mac_tx_data_valid,
  output logic                         mac_tx_start
);
  import udp_tx_pkg::*;

  tx_word_t    data_rd_data;
  logic        data_rd;
  logic        ctrl_rd;
  logic        ctrl_empty;
  ip_addr_t    ctrl_ip;
  udp_port_t   ctrl_port;
  word_count_t ctrl_words;
  mac_addr_t   next_hop_mac;
  word_count_t ip_length;
  word_count_t udp_length;
  logic [15:0] ip_checksum;

  // Port names match the nets one to one
  tx_ingress ingress_i (.*);

  arp_cache_apb arp_cache_i (.*);

  ip_header_calc hdr_calc_i (.*);

  udp_frame_tx framer_i (.*);

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 3
) (
  output logic mac_clk,
  output logic app_rst
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    mac_clk = 1'b0;
    forever #(HALF_PERIOD) mac_clk = ~mac_clk;
  end

  // Released just after an edge, like the other stimulus
  initial begin
    app_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge mac_clk);
    #2;
    app_rst = 1'b0;
  end

endmodule

`default_nettype wire

//--- dv/udp_tx_tb.sv
`default_nettype none

module udp_tx_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import udp_tx_pkg::*;

  localparam int MAX_WORDS = 20;
  localparam int N_LOCAL   = 12;
  localparam int N_GATEWAY = 4;
  localparam int N_MCAST   = 4;
  localparam int N_QUEUED  = 6;
  localparam int OVF_WORDS = 1030;
  localparam int N_FRAMES  = N_LOCAL + N_GATEWAY + N_MCAST + N_QUEUED;
  localparam int WATCHDOG_CYCLES = N_FRAMES * MAX_WORDS + OVF_WORDS + 60 * N_FRAMES + 2000;

  localparam mac_addr_t  LOCAL_MAC     = 48'h02_1a_2b_3c_4d_5e;
  localparam ip_addr_t   LOCAL_IP      = 32'h0a00_0005;   // 10.0.0.5
  localparam ip_addr_t   LOCAL_NETMASK = 32'hffff_ff00;
  localparam udp_port_t  LOCAL_PORT    = 16'h1f90;
  localparam arp_index_t LOCAL_GATEWAY = 8'h01;

  logic        mac_clk;
  logic        app_rst;
  logic        app_tx_valid;
  logic        app_tx_end_of_frame;
  tx_word_t    app_tx_data;
  ip_addr_t    app_tx_dest_ip;
  udp_port_t   app_tx_dest_port;
  logic        app_tx_afull;
  logic        app_tx_overflow;
  logic        local_enable;
  mac_addr_t   local_mac;
  ip_addr_t    local_ip;
  udp_port_t   local_port;
  arp_index_t  local_gateway;
  ip_addr_t    local_netmask;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [10:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        mac_tx_ack;
  tx_word_t    mac_tx_data;
  byte_mask_t  mac_tx_data_valid;
  logic        mac_tx_start;

  mac_addr_t  arp_model [256];   // Mirror of the table written over APB
  tx_word_t   pay_buf [MAX_WORDS];
  tx_word_t   exp_beat [$];
  byte_mask_t exp_mask [$];
  int         exp_len [$];       // Beats per expected frame
  int         frames_sent = 0;
  int         frames_done = 0;
  bit         block_starts = 1'b0;
  bit         afull_seen = 1'b0;

  tb_clk_gen clk_gen_i (
    .mac_clk (mac_clk),
    .app_rst (app_rst)
  );

  udp_tx_top dut_i (.*);

  task automatic step(input int cycles);
    repeat (cycles) @(posedge mac_clk);
    #2;
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("error: %s is %h, expected %h", name, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic apb_write(input logic [10:0] addr, input logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    step(1);
    penable = 1'b1;
    step(1);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [10:0] addr, output logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    step(1);
    penable = 1'b1;
    data    = prdata;   // Access phase
    step(1);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  function automatic mac_addr_t expected_dest_mac(input ip_addr_t ip);
    if (ip[31:28] == 4'b1110) begin
      return {24'h01005e, 1'b0, ip[22:0]};
    end
    if ((ip & LOCAL_NETMASK) == (LOCAL_IP & LOCAL_NETMASK)) begin
      return arp_model[ip[7:0]];
    end
    return arp_model[LOCAL_GATEWAY];
  endfunction

  // Builds the wire bytes of one frame and queues them as 8-byte beats
  function automatic void build_frame(input ip_addr_t dst_ip, input udp_port_t dst_port,
                                      input int n_words, input mac_addr_t dst_mac);
    logic [7:0]  fb [256];
    logic [15:0] ip_len;
    logic [15:0] udp_len;
    logic [31:0] sum;
    int          n_bytes;
    int          i;
    int          j;
    tx_word_t    beat;
    byte_mask_t  mask;
    ip_len  = 16'(28 + 8 * n_words);
    udp_len = 16'(8 + 8 * n_words);
    n_bytes = 42 + 8 * n_words;
    for (i = 0; i < 6; i++) begin
      fb[i]     = dst_mac[47 - 8 * i -: 8];
      fb[6 + i] = LOCAL_MAC[47 - 8 * i -: 8];
    end
    {fb[12], fb[13], fb[14], fb[15]} = {16'h0800, 8'h45, 8'h00};
    {fb[16], fb[17], fb[18], fb[19]} = {ip_len, 16'h0000};
    {fb[20], fb[21], fb[22], fb[23]} = {16'h4000, 8'h40, 8'h11};   // DF, TTL, UDP
    {fb[24], fb[25]} = 16'h0000;
    {fb[26], fb[27], fb[28], fb[29]} = LOCAL_IP;
    {fb[30], fb[31], fb[32], fb[33]} = dst_ip;
    {fb[34], fb[35], fb[36], fb[37]} = {LOCAL_PORT, dst_port};
    {fb[38], fb[39], fb[40], fb[41]} = {udp_len, 16'h0000};
    for (i = 0; i < 8 * n_words; i++) begin
      fb[42 + i] = pay_buf[i / 8][63 - 8 * (i % 8) -: 8];   // Word MSB goes first
    end
    // Header checksum over bytes 14 to 33
    sum = '0;
    for (i = 14; i < 34; i += 2) begin
      sum = sum + {16'h0000, fb[i], fb[i + 1]};
    end
    while (sum[31:16] != '0) begin
      sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
    end
    {fb[24], fb[25]} = ~sum[15:0];
    for (i = 0; i < n_bytes; i += 8) begin
      beat = '0;
      mask = '0;
      for (j = 0; j < 8 && i + j < n_bytes; j++) begin
        beat[8 * j +: 8] = fb[i + j];
        mask[j] = 1'b1;
      end
      exp_beat.push_back(beat);
      exp_mask.push_back(mask);
    end
    exp_len.push_back((n_bytes + 7) / 8);
  endfunction

  task automatic send_packet(input ip_addr_t ip, input udp_port_t port, input int n_words,
                             input bit expect_frame);
    int w;
    if (expect_frame) begin
      for (w = 0; w < n_words; w++) begin
        pay_buf[w] = {$urandom(), $urandom()};
      end
      build_frame(ip, port, n_words, expected_dest_mac(ip));
      frames_sent++;
    end
    for (w = 0; w < n_words; w++) begin
      app_tx_valid        = 1'b1;
      app_tx_data         = expect_frame ? pay_buf[w] : {$urandom(), $urandom()};
      app_tx_end_of_frame = (w == n_words - 1);
      app_tx_dest_ip      = ip;
      app_tx_dest_port    = port;
      step(1);
    end
    app_tx_valid        = 1'b0;
    app_tx_end_of_frame = 1'b0;
  endtask

  task automatic wait_drained();
    while (frames_done != frames_sent) begin
      step(1);
    end
  endtask

  // MAC side ack after a random delay
  initial begin : ack_responder
    int delay;
    mac_tx_ack = 1'b0;
    forever begin
      @(negedge mac_clk);
      if (mac_tx_start) begin
        delay = $urandom_range(0, 7);
        @(posedge mac_clk);
        repeat (delay) @(posedge mac_clk);
        #2;
        mac_tx_ack = 1'b1;
        @(posedge mac_clk);
        #2;
        mac_tx_ack = 1'b0;
      end
    end
  end

  // Compares each frame against the scoreboard
  initial begin : frame_monitor
    int         n_beats;
    int         k;
    tx_word_t   beat0;
    byte_mask_t mask0;
    forever begin
      @(negedge mac_clk);
      if (mac_tx_start) begin
        if (!local_enable || block_starts) begin
          abort_run("mac_tx_start appeared while frame starts should be blocked");
        end
        if (exp_len.size() == 0) begin
          abort_run("mac_tx_start appeared with no frame expected");
        end
        n_beats = exp_len.pop_front();
        beat0   = exp_beat.pop_front();
        mask0   = exp_mask.pop_front();
        do begin   // First beat holds until ack
          @(negedge mac_clk);
          check_value("mac_tx_data", mac_tx_data, beat0);
          check_value("mac_tx_data_valid", 64'(mac_tx_data_valid), 64'(mask0));
        end while (!mac_tx_ack);
        for (k = 1; k < n_beats; k++) begin
          @(negedge mac_clk);
          check_value("mac_tx_data", mac_tx_data, exp_beat.pop_front());
          check_value("mac_tx_data_valid", 64'(mac_tx_data_valid),
                      64'(exp_mask.pop_front()));
        end
        frames_done++;
      end
    end
  end

  always @(negedge mac_clk) begin
    if (app_tx_afull) begin
      afull_seen = 1'b1;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * 20);
    abort_run("Watchdog expired before the test finished");
  end

  initial begin
    int          i;
    int          n;
    logic [31:0] rd;
    ip_addr_t    ip;
    void'($urandom(32'hb3d9));
    app_tx_valid        = 1'b0;
    app_tx_end_of_frame = 1'b0;
    app_tx_data         = '0;
    app_tx_dest_ip      = '0;
    app_tx_dest_port    = '0;
    local_enable        = 1'b0;
    local_mac           = LOCAL_MAC;
    local_ip            = LOCAL_IP;
    local_port          = LOCAL_PORT;
    local_gateway       = LOCAL_GATEWAY;
    local_netmask       = LOCAL_NETMASK;
    psel                = 1'b0;
    penable             = 1'b0;
    pwrite              = 1'b0;
    paddr               = '0;
    pwdata              = '0;
    @(negedge app_rst);
    step(2);
    check_value("mac_tx_start", 64'(mac_tx_start), 64'h0);
    check_value("mac_tx_data_valid", 64'(mac_tx_data_valid), 64'h0);

    // Whole ARP table with junk in the unused upper half bits
    for (i = 0; i < 256; i++) begin
      arp_model[i] = {16'($urandom()), 32'($urandom())};
      apb_write({i[7:0], 3'b000}, arp_model[i][31:0]);
      apb_write({i[7:0], 3'b100}, {16'($urandom()), arp_model[i][47:32]});
    end
    for (i = 0; i < 8; i++) begin
      n = $urandom_range(0, 255);
      apb_read({n[7:0], 3'b000}, rd);
      check_value("prdata", 64'(rd), 64'(arp_model[n][31:0]));
      apb_read({n[7:0], 3'b100}, rd);
      check_value("prdata", 64'(rd), 64'(arp_model[n][47:32]));
    end

    local_enable = 1'b1;
    for (i = 0; i < N_LOCAL; i++) begin
      ip = {LOCAL_IP[31:8], 8'($urandom())};
      send_packet(ip, 16'($urandom()), $urandom_range(1, MAX_WORDS), 1'b1);
      wait_drained();
    end
    for (i = 0; i < N_GATEWAY; i++) begin
      ip = {16'hc0a8, 16'($urandom())};   // Off subnet
      send_packet(ip, 16'($urandom()), $urandom_range(1, MAX_WORDS), 1'b1);
      wait_drained();
    end
    for (i = 0; i < N_MCAST; i++) begin
      ip = {8'he0, 24'($urandom())};
      send_packet(ip, 16'($urandom()), $urandom_range(1, MAX_WORDS), 1'b1);
      wait_drained();
    end

    // Queue while disabled and release afterwards
    local_enable = 1'b0;
    for (i = 0; i < N_QUEUED; i++) begin
      ip = (i % 2 == 0) ? {LOCAL_IP[31:8], 8'($urandom())} : {8'he0, 24'($urandom())};
      send_packet(ip, 16'($urandom()), $urandom_range(1, MAX_WORDS), 1'b1);
    end
    step(50);
    local_enable = 1'b1;
    wait_drained();

    // Overflow the data FIFO
    local_enable = 1'b0;
    afull_seen   = 1'b0;
    check_value("app_tx_overflow", 64'(app_tx_overflow), 64'h0);
    send_packet(LOCAL_IP + 32'd1, 16'h1234, OVF_WORDS, 1'b0);
    step(3);
    check_value("app_tx_afull", 64'(afull_seen), 64'h1);
    check_value("app_tx_overflow", 64'(app_tx_overflow), 64'h1);
    block_starts = 1'b1;
    local_enable = 1'b1;
    repeat (200) begin
      step(1);
      check_value("app_tx_overflow", 64'(app_tx_overflow), 64'h1);
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+design
design/udp_tx_pkg.sv
design/sync_fifo.sv
design/tx_ingress.sv
design/arp_cache_apb.sv
design/ip_header_calc.sv
design/udp_frame_tx.sv
design/udp_tx_top.sv
dv/tb_clk_gen.sv
dv/udp_tx_tb.sv
